//--- sim.f
+incdir+source
source/bus_ctrl_pkg.sv
source/menu_fsm.sv
source/data_bank.sv
source/config_sequencer.sv
source/bus_ctrl_top.sv
verif/tb_bus_ctrl.sv

//--- run_sim.sh
#!/bin/bash
# builds the bus control testbench with Verilator, runs it and checks the log

top=tb_bus_ctrl
log=sim.log

rm -rf obj_dir "$log"
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module "$top" -o "$top" \
    || { echo "build failed"; exit 1; }
./obj_dir/"$top" > "$log" 2>&1 || echo "simulator returned an error"
cat "$log"
grep -qx "ALL CHECKS PASSED" "$log" && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

//--- verif/tb_bus_ctrl.sv
`include "bus_ctrl_consts.svh"

module tb_bus_ctrl;

    localparam int wait_limit = 100;                // cycles allowed for any single wait

    logic clk;
    logic rstN;
    logic [`BC_SW_W-1:0] sw;
    logic step_n;
    logic next_addr_n;
    logic [`BC_MASTERS-1:0] done_com;
    logic [`BC_MASTERS-1:0][`BC_SID_W-1:0] m_slave_id;
    logic [`BC_MASTERS-1:0] m_rd_wr;
    logic [`BC_MASTERS-1:0] m_in_ex;
    logic [`BC_MASTERS-1:0] m_burst;
    logic [`BC_MASTERS-1:0] m_start;
    logic [`BC_MASTERS-1:0] m_eoc;
    logic [`BC_MASTERS-1:0][`BC_ADDR_W-1:0] m_address;
    logic [`BC_MASTERS-1:0][`BC_DATA_W-1:0] m_data;
    logic st_idle;
    logic st_ready;
    logic st_busy;
    logic st_done;

    int errors = 0;
    int checks = 0;
    int cyc = 0;
    int start_cyc;                                  // cycle of the last seen start pulse
    int start_cnt [`BC_MASTERS];                    // start pulses per master since reset
    int seed = 32'h67f0ddde;
    logic [`BC_DATA_W-1:0] words0 [$];
    logic [`BC_DATA_W-1:0] words1 [$];

    bus_ctrl_top u_dut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    always @(negedge clk) begin
        for (int m = 0; m < `BC_MASTERS; m++) begin
            if (!rstN) begin
                start_cnt[m] = 0;
            end else if (m_start[m] === 1'b1) begin
                start_cnt[m] = start_cnt[m] + 1;
            end
        end
    end

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // end address rule: first address plus length, held below the slave depth
    function automatic int clamped_end(input int depth, input int base, input int len);
        return (base + len > depth - 1) ? depth - 1 : base + len;
    endfunction

    task automatic apply_reset();
        rstN = 1'b0;
        done_com = '0;
        repeat (4) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic press_step(input logic [`BC_SW_W-1:0] val);
        @(negedge clk);
        sw = val;
        step_n = 1'b0;
        @(negedge clk);
        step_n = 1'b1;
    endtask

    task automatic press_next(input logic [`BC_SW_W-1:0] val);
        @(negedge clk);
        sw = val;
        next_addr_n = 1'b0;
        @(negedge clk);
        next_addr_n = 1'b1;
    endtask

    // want_done picks st_done, otherwise st_ready
    task automatic wait_status(input bit want_done);
        int n;
        n = 0;
        while ((want_done ? st_done : st_ready) !== 1'b1) begin
            if (n == wait_limit) begin
                $display("timeout: menu never reached the %s state", want_done ? "done" : "ready");
                errors++;
                finish_run();
            end
            @(negedge clk);
            n++;
        end
    endtask

    // walks the whole menu, bank words come from words0 and words1
    task automatic run_menu(input logic [3:0] sids, input logic [1:0] inex,
                            input logic [11:0] fa0, input logic [11:0] fa1,
                            input logic [11:0] len0, input logic [11:0] len1);
        press_step(sids);
        press_step(2'b01);                          // master 0 reads, master 1 writes
        press_step(inex);
        if (inex[0]) begin
            foreach (words0[i]) press_next(words0[i]);
            press_step('0);
        end
        if (inex[1]) begin
            foreach (words1[i]) press_next(words1[i]);
            press_step('0);
        end
        press_step(fa0);
        press_step(fa1);
        press_step(len0);
        press_step(len1);                           // this press starts configuration
    endtask

    task automatic expect_start(input int m, input logic [11:0] addr,
                                input bit chk_data, input logic [15:0] data);
        int n;
        n = 0;
        while (m_start[m] !== 1'b1) begin
            if (n == wait_limit) begin
                $display("timeout: no start pulse seen on master %0d", m);
                errors++;
                finish_run();
            end
            @(negedge clk);
            n++;
        end
        start_cyc = cyc;
        check_eq($sformatf("m_address[%0d]", m), m_address[m], addr);
        if (chk_data) check_eq($sformatf("m_data[%0d]", m), m_data[m], data);
        @(negedge clk);
    endtask

    task automatic test_reset_skip();
        apply_reset();
        check_eq("st_idle", st_idle, 1);
        check_eq("m_start", m_start, 0);
        check_eq("m_eoc", m_eoc, 0);
        press_step('0);                             // both slave ids 0
        check_eq("st_done", st_done, 1);
        check_eq("m_eoc", m_eoc, 2'b11);
    endtask

    task automatic test_internal_launch();
        int first_cyc;
        int exp0;
        int exp1;
        exp0 = clamped_end(`BC_SLAVE3_DEPTH, 2000, 500);
        exp1 = clamped_end(`BC_SLAVE1_DEPTH, 10, 5);
        apply_reset();
        words0 = {};
        words1 = {};
        run_menu(4'b0111, 2'b00, 2000, 10, 500, 5);   // master 0 on slave 3, master 1 on slave 1
        check_eq("m_slave_id", m_slave_id, 4'b0111);
        check_eq("m_rd_wr", m_rd_wr, 2'b01);
        expect_start(0, 2000, 0, 0);
        first_cyc = start_cyc;
        expect_start(0, exp0, 0, 0);
        check_eq("m_start[0] spacing", start_cyc - first_cyc, `BC_PHASE_CLKS);
        expect_start(1, 10, 0, 0);
        first_cyc = start_cyc;
        expect_start(1, exp1, 0, 0);
        check_eq("m_start[1] spacing", start_cyc - first_cyc, `BC_PHASE_CLKS);
        wait_status(0);
        check_eq("m_start[0] pulses", start_cnt[0], 2);
        check_eq("m_start[1] pulses", start_cnt[1], 2);
        check_eq("m_start", m_start, 0);
        check_eq("m_address", m_address, 0);
        press_step('0);                             // launch
        check_eq("m_start", m_start, 2'b11);
        @(negedge clk);
        check_eq("m_start", m_start, 0);
        check_eq("st_busy", st_busy, 1);
        done_com = 2'b01;
        repeat (5) @(negedge clk);
        check_eq("st_done", st_done, 0);            // master 1 still running
        done_com = 2'b11;
        wait_status(1);
    endtask

    task automatic test_external();
        logic [31:0] r;
        int i;
        apply_reset();
        words0 = {};
        words1 = {};
        for (i = 0; i < 5; i++) begin
            r = $random(seed);
            if (i < 4) words0.push_back(r[`BC_DATA_W-1:0]);
            else words1.push_back(r[`BC_DATA_W-1:0]);
        end
        run_menu(4'b0101, 2'b11, 100, 200, 3, 0);
        check_eq("m_burst", m_burst, 2'b11);
        check_eq("m_in_ex", m_in_ex, 2'b11);
        expect_start(0, 100, 1, words0[0]);
        for (i = 1; i < 4; i++) begin
            repeat (`BC_PHASE_CLKS) @(negedge clk);   // lands in the second cycle of phase i
            check_eq($sformatf("m_data[0] phase %0d", i), m_data[0], words0[i]);
        end
        expect_start(1, 200, 1, words1[0]);
        wait_status(0);
        check_eq("m_start[0] pulses", start_cnt[0], 2);   // none in the middle phases
        check_eq("m_start[1] pulses", start_cnt[1], 2);
    endtask

    task automatic test_single_master();
        apply_reset();
        words0 = {};
        words1 = {};
        run_menu(4'b0010, 2'b00, 300, 0, 20, 0);   // master 1 unused
        wait_status(0);
        press_step('0);
        check_eq("st_done", st_done, 0);            // master 0 not finished yet
        done_com = 2'b01;
        wait_status(1);
    endtask

    initial begin
        sw = '0;
        step_n = 1'b1;
        next_addr_n = 1'b1;
        done_com = '0;
        rstN = 1'b0;
        test_reset_skip();
        test_internal_launch();
        test_external();
        test_single_master();
        finish_run();
    end

endmodule

//--- source/bus_ctrl_top.sv
`include "bus_ctrl_consts.svh"

module bus_ctrl_top import bus_ctrl_pkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic [`BC_SW_W-1:0] sw,
    input  logic step_n,
    input  logic next_addr_n,
    input  logic [`BC_MASTERS-1:0] done_com,
    output logic [`BC_MASTERS-1:0][`BC_SID_W-1:0] m_slave_id,
    output logic [`BC_MASTERS-1:0] m_rd_wr,
    output logic [`BC_MASTERS-1:0] m_in_ex,
    output logic [`BC_MASTERS-1:0] m_burst,
    output logic [`BC_MASTERS-1:0] m_start,
    output logic [`BC_MASTERS-1:0] m_eoc,
    output logic [`BC_MASTERS-1:0][`BC_ADDR_W-1:0] m_address,
    output logic [`BC_MASTERS-1:0][`BC_DATA_W-1:0] m_data,
    output logic st_idle,
    output logic st_ready,
    output logic st_busy,
    output logic st_done
);

    menu_state_t state;
    logic [`BC_MASTERS-1:0][`BC_ADDR_W-1:0] first_addr;
    logic [`BC_MASTERS-1:0][`BC_ADDR_W-1:0] last_addr;
    logic [`BC_MASTERS-1:0][`BC_CNT_W-1:0] wr_count;
    logic [`BC_MID_W-1:0] rd_master;
    logic [`BC_IDX_W-1:0] rd_index;
    logic [`BC_DATA_W-1:0] rd_word;
    logic cfg_go;
    logic launch;
    logic cfg_done;

    menu_fsm u_menu (
        .clk, .rstN, .sw, .step_n, .next_addr_n, .done_com, .cfg_done,
        .state, .slave_id(m_slave_id), .rd_wr(m_rd_wr), .in_ex(m_in_ex), .burst(m_burst),
        .first_addr, .last_addr, .m_eoc, .cfg_go, .launch,
        .st_idle, .st_ready, .st_busy, .st_done
    );

    data_bank u_bank (
        .clk, .rstN, .state, .sw, .step_n, .next_addr_n,
        .rd_master, .rd_index, .wr_count, .rd_word
    );

    config_sequencer u_seq (
        .clk, .rstN, .cfg_go, .launch, .in_ex(m_in_ex), .wr_count, .rd_word,
        .first_addr, .last_addr, .rd_master, .rd_index, .cfg_done,
        .m_start, .m_address, .m_data
    );

endmodule

//--- source/config_sequencer.sv
`include "bus_ctrl_consts.svh"

module config_sequencer import bus_ctrl_pkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic cfg_go,
    input  logic launch,
    input  logic [`BC_MASTERS-1:0] in_ex,
    input  logic [`BC_MASTERS-1:0][`BC_CNT_W-1:0] wr_count,
    input  logic [`BC_DATA_W-1:0] rd_word,
    input  logic [`BC_MASTERS-1:0][`BC_ADDR_W-1:0] first_addr,
    input  logic [`BC_MASTERS-1:0][`BC_ADDR_W-1:0] last_addr,
    output logic [`BC_MID_W-1:0] rd_master,
    output logic [`BC_IDX_W-1:0] rd_index,
    output logic cfg_done,
    output logic [`BC_MASTERS-1:0] m_start,
    output logic [`BC_MASTERS-1:0][`BC_ADDR_W-1:0] m_address,
    output logic [`BC_MASTERS-1:0][`BC_DATA_W-1:0] m_data
);

    localparam int cnt_w = `BC_CNT_W;
    localparam int clk_w = (`BC_PHASE_CLKS > 1) ? $clog2(`BC_PHASE_CLKS) : 1;

    cfg_phase_t phase;
    logic [clk_w-1:0] clk_cnt;                  // cycle within the current phase
    logic [`BC_MID_W-1:0] cur_master;
    logic [cnt_w-1:0] word_idx;                 // current phase number, also the bank word
    logic [cnt_w-1:0] next_idx;
    logic [cnt_w-1:0] last_idx;
    logic start_all;                            // launch start, one cycle after launch

    // P = max(2, wr_count) for external data, 2 otherwise
    always_comb begin
        last_idx = cnt_w'(1);
        if (in_ex[cur_master] && wr_count[cur_master] > cnt_w'(2)) begin
            last_idx = wr_count[cur_master] - 1'b1;
        end
    end

    assign next_idx = word_idx + 1'b1;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= cfg_idle;
            clk_cnt <= '0;
            cur_master <= '0;
            word_idx <= '0;
            cfg_done <= 1'b0;
            start_all <= 1'b0;
        end else begin
            cfg_done <= 1'b0;
            start_all <= launch;
            if (phase == cfg_idle) begin
                if (cfg_go) begin
                    phase <= cfg_start;
                    clk_cnt <= '0;
                    cur_master <= '0;
                    word_idx <= '0;
                end
            end else if (clk_cnt == `BC_PHASE_CLKS - 1) begin
                clk_cnt <= '0;
                if (phase == cfg_last) begin
                    word_idx <= '0;
                    if (cur_master == `BC_MASTERS - 1) begin
                        phase <= cfg_idle;
                        cfg_done <= 1'b1;           // menu moves on to comm_ready
                    end else begin
                        cur_master <= cur_master + 1'b1;
                        phase <= cfg_start;
                    end
                end else begin
                    word_idx <= next_idx;
                    phase <= (next_idx == last_idx) ? cfg_last : cfg_middle;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    assign rd_master = cur_master;
    assign rd_index = word_idx[`BC_IDX_W-1:0];

    // only the master under configuration sees address and data
    always_comb begin
        m_start = {`BC_MASTERS{start_all}};
        m_address = '0;
        m_data = '0;
        if (phase != cfg_idle) begin
            m_start[cur_master] = (phase == cfg_start || phase == cfg_last) && clk_cnt == '0;
            m_address[cur_master] = (phase == cfg_start) ? first_addr[cur_master]
                                                         : last_addr[cur_master];
            m_data[cur_master] = rd_word;
        end
    end

    // masters read start as a pulse, a level would restart them
    for (genvar m = 0; m < `BC_MASTERS; m++) begin : g_start_chk
        a_start_pulse: assert property (@(posedge clk) disable iff (!rstN)
            m_start[m] |=> !m_start[m]);
    end

endmodule

//--- source/data_bank.sv
`include "bus_ctrl_consts.svh"

module data_bank import bus_ctrl_pkg::*; (
    input  logic clk,
    input  logic rstN,
    input  menu_state_t state,
    input  logic [`BC_SW_W-1:0] sw,
    input  logic step_n,
    input  logic next_addr_n,
    input  logic [`BC_MID_W-1:0] rd_master,
    input  logic [`BC_IDX_W-1:0] rd_index,
    output logic [`BC_MASTERS-1:0][`BC_CNT_W-1:0] wr_count,
    output logic [`BC_DATA_W-1:0] rd_word
);

    sw_word_u sw_word;
    logic [`BC_DATA_W-1:0] bank [`BC_MASTERS][`BC_BANK_DEPTH];
    logic [`BC_CNT_W-1:0] wr_idx;                           // shared by both masters
    logic [`BC_MID_W-1:0] wr_master;
    logic ext_state;
    logic wr_en;

    assign sw_word = sw;
    assign ext_state = state inside {ext_write_m0, ext_write_both, ext_write_m1};

    always_comb begin
        wr_master = '0;
        wr_master[0] = state == ext_write_m1;               // ext_write_both fills master 0
    end

    // a step press in the same cycle wins over the next-address press
    assign wr_en = ext_state && step_n && !next_addr_n && wr_idx != `BC_BANK_DEPTH;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            bank[wr_master][wr_idx[`BC_IDX_W-1:0]] <= sw_word.data.word;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wr_idx <= '0;
            wr_count <= '0;
        end else if (!step_n) begin
            wr_idx <= '0;                                   // next master starts at word 0
        end else if (wr_en) begin
            wr_idx <= wr_idx + 1'b1;
            wr_count[wr_master] <= wr_count[wr_master] + 1'b1;
        end
    end

    assign rd_word = bank[rd_master][rd_index];

    a_no_overflow: assert property (@(posedge clk) disable iff (!rstN)
        wr_idx == `BC_BANK_DEPTH |=> $stable(wr_count));

endmodule

//--- source/menu_fsm.sv
`include "bus_ctrl_consts.svh"

module menu_fsm import bus_ctrl_pkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic [`BC_SW_W-1:0] sw,
    input  logic step_n,
    input  logic next_addr_n,
    input  logic [`BC_MASTERS-1:0] done_com,
    input  logic cfg_done,
    output menu_state_t state,
    output logic [`BC_MASTERS-1:0][`BC_SID_W-1:0] slave_id,
    output logic [`BC_MASTERS-1:0] rd_wr,
    output logic [`BC_MASTERS-1:0] in_ex,
    output logic [`BC_MASTERS-1:0] burst,
    output logic [`BC_MASTERS-1:0][`BC_ADDR_W-1:0] first_addr,
    output logic [`BC_MASTERS-1:0][`BC_ADDR_W-1:0] last_addr,
    output logic [`BC_MASTERS-1:0] m_eoc,
    output logic cfg_go,
    output logic launch,
    output logic st_idle,
    output logic st_ready,
    output logic st_busy,
    output logic st_done
);

    // highest legal address per slave id, id 0 keeps the full master range
    localparam int unsigned slave_top [2**`BC_SID_W] = '{
        `BC_SLAVE1_DEPTH - 1,
        `BC_SLAVE1_DEPTH - 1,
        `BC_SLAVE2_DEPTH - 1,
        `BC_SLAVE3_DEPTH - 1
    };

    menu_state_t next_state;
    sw_word_u sw_word;
    logic step;
    logic next_press;
    logic all_done;

    function automatic logic [`BC_ADDR_W-1:0] clamp_end(
        input logic [`BC_SID_W-1:0] sid,
        input logic [`BC_ADDR_W-1:0] base,
        input logic [`BC_ADDR_W-1:0] len
    );
        logic [`BC_ADDR_W:0] sum;
        sum = {1'b0, base} + {1'b0, len};   // one extra bit so the sum cannot wrap
        if (sum > slave_top[sid]) begin
            return slave_top[sid][`BC_ADDR_W-1:0];
        end
        return sum[`BC_ADDR_W-1:0];
    endfunction

    assign sw_word = sw;
    assign step = !step_n;
    assign next_press = !next_addr_n;

    // an unused master never blocks completion
    always_comb begin
        all_done = 1'b1;
        for (int m = 0; m < `BC_MASTERS; m++) begin
            if (slave_id[m] != '0 && !done_com[m]) begin
                all_done = 1'b0;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            slave_sel: if (step) next_state = (sw_word.sel.sid == '0) ? comm_done : rw_sel;
            rw_sel: if (step) next_state = ext_sel;
            ext_sel: begin
                if (step) begin
                    case (sw[`BC_MASTERS-1:0])
                        2'b01: next_state = ext_write_m0;
                        2'b10: next_state = ext_write_m1;
                        2'b11: next_state = ext_write_both;
                        default: next_state = start_addr_m0;
                    endcase
                end
            end
            ext_write_m0: if (step) next_state = start_addr_m0;
            ext_write_both: if (step) next_state = ext_write_m1;
            ext_write_m1: if (step) next_state = start_addr_m0;
            start_addr_m0: if (step) next_state = start_addr_m1;
            start_addr_m1: if (step) next_state = end_addr_m0;
            end_addr_m0: if (step) next_state = end_addr_m1;
            end_addr_m1: if (step) next_state = configuring;
            configuring: if (cfg_done) next_state = comm_ready;
            comm_ready: if (step) next_state = communicating;
            communicating: if (all_done) next_state = comm_done;
            default: next_state = state;                    // comm_done holds until reset
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= slave_sel;
            slave_id <= '0;
            rd_wr <= '0;
            in_ex <= '0;
            burst <= '0;
            first_addr <= '0;
            last_addr <= '0;
            m_eoc <= '0;
        end else begin
            state <= next_state;
            if (step) begin
                case (state)
                    slave_sel: begin
                        slave_id <= sw_word.sel.sid;
                        if (sw_word.sel.sid == '0) begin
                            m_eoc <= '1;                    // masters skip straight to their end
                        end
                    end
                    rw_sel: rd_wr <= sw[`BC_MASTERS-1:0];
                    ext_sel: in_ex <= sw[`BC_MASTERS-1:0];
                    start_addr_m0: first_addr[0] <= sw_word.addr.addr;
                    start_addr_m1: first_addr[1] <= sw_word.addr.addr;
                    end_addr_m0: last_addr[0] <= clamp_end(slave_id[0], first_addr[0],
                                                           sw_word.addr.addr);
                    end_addr_m1: last_addr[1] <= clamp_end(slave_id[1], first_addr[1],
                                                           sw_word.addr.addr);
                    default: ;
                endcase
            end else if (next_press) begin
                if (state == ext_write_m0 || state == ext_write_both) begin
                    burst[0] <= 1'b1;
                end else if (state == ext_write_m1) begin
                    burst[1] <= 1'b1;
                end
            end
        end
    end

    assign cfg_go = step && state == end_addr_m1;
    assign launch = step && state == comm_ready;

    assign st_idle = state == slave_sel;
    assign st_ready = state == comm_ready;
    assign st_busy = state == communicating;
    assign st_done = state == comm_done;

    a_go_launch: assert property (@(posedge clk) disable iff (!rstN) !(cfg_go && launch));

    // clamped end address must still be valid once the masters are set up
    for (genvar m = 0; m < `BC_MASTERS; m++) begin : g_addr_chk
        a_addr_in_slave: assert property (@(posedge clk) disable iff (!rstN)
            (state inside {configuring, comm_ready, communicating} && slave_id[m] != '0)
            |-> last_addr[m] <= slave_top[slave_id[m]]);
    end

endmodule

//--- source/bus_ctrl_pkg.sv
`include "bus_ctrl_consts.svh"

package bus_ctrl_pkg;

    typedef enum logic [3:0] {
        slave_sel,
        rw_sel,
        ext_sel,
        ext_write_m0,
        ext_write_both,         // master 0 words first, then master 1
        ext_write_m1,
        start_addr_m0,
        start_addr_m1,
        end_addr_m0,
        end_addr_m1,
        configuring,
        comm_ready,
        communicating,
        comm_done
    } menu_state_t;

    typedef enum logic [1:0] {
        cfg_start,              // phase 0 of a master
        cfg_middle,
        cfg_last,               // phase P-1 of a master
        cfg_idle
    } cfg_phase_t;

    typedef struct packed {
        logic [`BC_SW_W-`BC_MASTERS*`BC_SID_W-1:0] rsvd;
        logic [`BC_MASTERS-1:0][`BC_SID_W-1:0] sid;    // master 1 in bits 3:2
    } sw_sel_t;

    typedef struct packed {
        logic [`BC_SW_W-`BC_ADDR_W-1:0] rsvd;
        logic [`BC_ADDR_W-1:0] addr;
    } sw_addr_t;

    typedef struct packed {
        logic [`BC_SW_W-`BC_DATA_W-1:0] rsvd;
        logic [`BC_DATA_W-1:0] word;
    } sw_data_t;

    // one switch word, read according to the menu state
    typedef union packed {
        sw_sel_t sel;
        sw_addr_t addr;
        sw_data_t data;
    } sw_word_u;

endpackage

//--- source/bus_ctrl_consts.svh
`ifndef BUS_CTRL_CONSTS_SVH
`define BUS_CTRL_CONSTS_SVH

`define BC_MASTERS 2        // configured bus masters
`define BC_DATA_W 16        // master data word
`define BC_ADDR_W 12        // master address range
`define BC_SID_W 2          // slave id, 0 leaves the master unused
`define BC_SW_W 18          // switch bank

`define BC_BANK_DEPTH 16    // stored words per master

// slave depths, indexed by slave id 1..3
`define BC_SLAVE1_DEPTH 4096
`define BC_SLAVE2_DEPTH 4096
`define BC_SLAVE3_DEPTH 2048

`define BC_PHASE_CLKS 2     // cycles per configuration phase

// derived widths
`define BC_CNT_W ($clog2(`BC_BANK_DEPTH + 1))
`define BC_IDX_W ($clog2(`BC_BANK_DEPTH))
`define BC_MID_W ($clog2(`BC_MASTERS))

`endif
